/* flist.f */
source/ingress_pkg.sv
source/ingress_width_packer.sv
source/ingress_port_fifo.sv
source/ingress_port_counters.sv
source/ingress_rr_arbiter.sv
source/router_ingress_top.sv
test/tb_clock_gen.sv
test/ingress_properties.sv
test/ingress_tb.sv

/* test/ingress_tb.sv */
// Testbench for the router ingress stage with random packets and a packet-level model
// Runs sequential, concurrent, counter, disable and overflow tests, then prints a summary
`timescale 1ns/1ps

module ingress_tb;

    import ingress_pkg::*;

    localparam int seq_pkts        = 12;
    localparam int conc_pkts       = 6;
    localparam int dis_pkts        = 4;
    localparam int total_pkts      = seq_pkts + (conc_pkts + dis_pkts) * num_ports + 5;
    localparam int watchdog_cycles = total_pkts * 64 * 4 + 1000;

    logic                 clk_ifc;
    logic                 rst_n;
    in8_beat_t            in_8b [num_8b_ports];
    in32_beat_t           in_32b [num_32b_ports];
    logic [num_ports-1:0] port_enable;
    logic [num_ports-1:0] cnt_clear;
    bus_word_t            out_word;
    logic                 out_valid;
    logic                 out_ready;
    logic [cnt_w-1:0]     frame_cnt [num_ports];
    logic [cnt_w-1:0]     byte_cnt [num_ports];
    logic [num_ports-1:0] buf_overflow;

    // Stimulus still to be driven, per port
    logic [7:0] tx_bytes [num_ports][$];
    int         tx_len [num_ports][$];
    // Reference model, per port
    logic [7:0] exp_bytes [num_ports][$];
    int         exp_len [num_ports][$];
    int         exp_frames [num_ports];
    int         exp_bytecnt [num_ports];

    integer     seed;
    string      test_name;
    int         errors;
    int         checks;
    int         tests_run;
    int         errs_at_start;
    logic       mon_in_pkt;
    logic [1:0] mon_port;
    int         mon_count;

    tb_clock_gen u_clk (
        .clk_ifc ( clk_ifc )
    );

    router_ingress_top UUT (
        .clk_ifc      ( clk_ifc      ),
        .rst_n        ( rst_n        ),
        .in_8b        ( in_8b        ),
        .in_32b       ( in_32b       ),
        .port_enable  ( port_enable  ),
        .cnt_clear    ( cnt_clear    ),
        .out_word     ( out_word     ),
        .out_valid    ( out_valid    ),
        .out_ready    ( out_ready    ),
        .frame_cnt    ( frame_cnt    ),
        .byte_cnt     ( byte_cnt     ),
        .buf_overflow ( buf_overflow )
    );

    ////////////////////////////////////////
    // Checking helpers

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (exp === act) else begin
            $display("CHECK FAILED %s %s: expected %0h actual %0h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("%s: %s", test_name, msg);
            errors++;
        end
    endtask

    task automatic check_counters();
        for (int p = 0; p < num_ports; p++) begin
            check_value($sformatf("frame_cnt[%0d]", p), exp_frames[p], frame_cnt[p]);
            check_value($sformatf("byte_cnt[%0d]", p), exp_bytecnt[p], byte_cnt[p]);
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errs_at_start = errors;
    endtask

    task automatic finish_test(input logic [num_ports-1:0] exp_ovf);
        check_value("buf_overflow", exp_ovf, buf_overflow);
        tests_run++;
        $display("test %-14s done, %0d errors", test_name, errors - errs_at_start);
    endtask

    ////////////////////////////////////////
    // Stimulus

    // Whole beats only, 8 to 64 bytes
    function automatic int rand_len(input int p);
        if (p < num_8b_ports) begin
            return 8 + int'($unsigned($random(seed)) % 57);
        end
        return 4 * (2 + int'($unsigned($random(seed)) % 15));
    endfunction

    task automatic queue_packet(input int p, input int len, input logic modeled);
        logic [7:0] b;
        for (int i = 0; i < len; i++) begin
            b = 8'($random(seed));
            tx_bytes[p].push_back(b);
            if (modeled) begin
                exp_bytes[p].push_back(b);
            end
        end
        tx_len[p].push_back(len);
        if (modeled) begin
            exp_len[p].push_back(len);
            exp_frames[p]++;
            exp_bytecnt[p] += len;
        end
    endtask

    task automatic drive_beat(input int p, input logic v, input logic [31:0] d, input logic l);
        if (p < num_8b_ports) begin
            in_8b[p] = '{valid: v, data: d[7:0], last: l};
        end else begin
            in_32b[p - num_8b_ports] = '{valid: v, data: d, last: l};
        end
    endtask

    // One beat per port per cycle, 32-bit ports on about half the cycles
    task automatic run_traffic();
        int          rem [num_ports];
        int          w;
        logic        busy;
        logic        v;
        logic        l;
        logic [31:0] d;
        for (int p = 0; p < num_ports; p++) begin
            rem[p] = 0;
        end
        busy = 1'b1;
        while (busy) begin
            @(negedge clk_ifc);
            busy = 1'b0;
            for (int p = 0; p < num_ports; p++) begin
                w = (p < num_8b_ports) ? 1 : 4;
                v = 1'b0;
                l = 1'b0;
                d = '0;
                if (rem[p] == 0 && tx_len[p].size() > 0) begin
                    rem[p] = tx_len[p].pop_front();
                end
                if (rem[p] > 0 && (w == 1 || $random(seed) & 1)) begin
                    for (int b = 0; b < w; b++) begin
                        d[b*8 +: 8] = tx_bytes[p].pop_front();
                    end
                    rem[p] -= w;
                    v = 1'b1;
                    l = (rem[p] == 0);
                end
                drive_beat(p, v, d, l);
                if (rem[p] > 0 || tx_len[p].size() > 0) begin
                    busy = 1'b1;
                end
            end
        end
        @(negedge clk_ifc);
        for (int p = 0; p < num_ports; p++) begin
            drive_beat(p, 1'b0, '0, 1'b0);
        end
    endtask

    // Waits until every modeled packet came out, then a quiet stretch
    task automatic wait_drain();
        logic pending;
        pending = 1'b1;
        while (pending) begin
            @(negedge clk_ifc);
            pending = 1'b0;
            for (int p = 0; p < num_ports; p++) begin
                if (exp_len[p].size() > 0) begin
                    pending = 1'b1;
                end
            end
        end
        repeat (20) @(negedge clk_ifc);
    endtask

    ////////////////////////////////////////
    // Output monitor

    task automatic take_word(input bus_word_t w);
        int         p;
        int         len;
        logic [7:0] exp_b;
        logic [7:0] keep_inc;
        if (!mon_in_pkt) begin
            mon_port   = w.port;
            mon_count  = 0;
            mon_in_pkt = 1'b1;
        end else begin
            // No other port may cut into a packet
            check_value("port index", mon_port, w.port);
        end
        keep_inc = w.keep + 8'd1;
        check_true(w.keep != '0 && (w.keep & keep_inc) == '0,
                   "keep bits not contiguous from byte 0");
        p = int'(mon_port);
        for (int b = 0; b < bus_bytes; b++) begin
            if (w.keep[b]) begin
                mon_count++;
                if (exp_bytes[p].size() > 0) begin
                    exp_b = exp_bytes[p].pop_front();
                    check_value("data byte", exp_b, w.data[b*8 +: 8]);
                end else begin
                    check_true(1'b0, $sformatf("unexpected output byte from port %0d", p));
                end
            end
        end
        if (w.last) begin
            mon_in_pkt = 1'b0;
            if (exp_len[p].size() > 0) begin
                len = exp_len[p].pop_front();
                check_value("packet length", len, mon_count);
            end else begin
                check_true(1'b0, $sformatf("unexpected packet end from port %0d", p));
            end
        end
    endtask

    always @(posedge clk_ifc) begin
        if (rst_n && out_valid && out_ready) begin
            take_word(out_word);
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk_ifc);
        $display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("Checks failed");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence

    initial begin
        int sel;
        seed        = 32'hf82c_3e18;
        rst_n       = 1'b0;
        out_ready   = 1'b1;
        port_enable = '1;
        cnt_clear   = '0;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        mon_in_pkt  = 1'b0;
        mon_port    = '0;
        mon_count   = 0;
        for (int p = 0; p < num_ports; p++) begin
            drive_beat(p, 1'b0, '0, 1'b0);
            exp_frames[p]  = 0;
            exp_bytecnt[p] = 0;
        end
        repeat (3) @(negedge clk_ifc);
        rst_n = 1'b1;
        @(negedge clk_ifc);

        start_test("sequential");
        for (int i = 0; i < seq_pkts; i++) begin
            sel = int'($unsigned($random(seed)) % num_ports);
            queue_packet(sel, rand_len(sel), 1'b1);
            run_traffic();
            wait_drain();
        end
        finish_test('0);

        start_test("concurrent");
        for (int k = 0; k < conc_pkts; k++) begin
            for (int p = 0; p < num_ports; p++) begin
                queue_packet(p, rand_len(p), 1'b1);
            end
        end
        run_traffic();
        wait_drain();
        finish_test('0);

        start_test("counters");
        check_counters();
        sel = int'($unsigned($random(seed)) % num_ports);
        cnt_clear[sel] = 1'b1;
        @(negedge clk_ifc);
        cnt_clear = '0;
        exp_frames[sel]  = 0;
        exp_bytecnt[sel] = 0;
        check_counters();
        finish_test('0);

        // Disabled port is left out of the model
        start_test("port_disable");
        sel = int'($unsigned($random(seed)) % num_ports);
        port_enable[sel] = 1'b0;
        for (int k = 0; k < dis_pkts; k++) begin
            for (int p = 0; p < num_ports; p++) begin
                queue_packet(p, rand_len(p), p != sel);
            end
        end
        run_traffic();
        wait_drain();
        check_counters();
        port_enable = '1;
        finish_test('0);

        // 34 words into one port with the sink stalled
        start_test("overflow");
        sel = int'($unsigned($random(seed)) % num_ports);
        out_ready = 1'b0;
        for (int k = 0; k < 4; k++) begin
            queue_packet(sel, 64, 1'b0);
        end
        queue_packet(sel, 16, 1'b0);
        run_traffic();
        repeat (4) @(negedge clk_ifc);
        finish_test(num_ports'(1) << sel);

        // Bound assertion failures count as errors too
        errors += UUT.u_props.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* test/ingress_properties.sv */
// Bus and overflow flag assertions for the router ingress stage
// Attached to router_ingress_top by the bind at the end of this file
`timescale 1ns/1ps

module ingress_properties (
    input  logic                              clk_ifc,
    input  logic                              rst_n,
    input  ingress_pkg::bus_word_t            out_word,
    input  logic                              out_valid,
    input  logic                              out_ready,
    input  logic [ingress_pkg::num_ports-1:0] buf_overflow
);

    import ingress_pkg::*;

    // Assertion failures so far
    int fail_count = 0;

    // A stalled word stays put until the sink takes it
    a_stall_stable: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_word))
        else begin
            $error("out_word or out_valid changed while stalled");
            fail_count++;
        end

    a_keep_nonzero: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        out_valid |-> out_word.keep != '0)
        else begin
            $error("out_valid high with an empty keep");
            fail_count++;
        end

    // Overflow flags are sticky
    a_overflow_sticky: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        !(|($past(buf_overflow) & ~buf_overflow)))
        else begin
            $error("buf_overflow bit fell outside reset");
            fail_count++;
        end

endmodule

bind router_ingress_top ingress_properties u_props (
    .clk_ifc      ( clk_ifc      ),
    .rst_n        ( rst_n        ),
    .out_word     ( out_word     ),
    .out_valid    ( out_valid    ),
    .out_ready    ( out_ready    ),
    .buf_overflow ( buf_overflow )
);

/* test/tb_clock_gen.sv */
// Free-running clock for the ingress testbench, 10 ns period
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real period_ns = 10.0
) (
    output logic clk_ifc
);

    initial begin
        clk_ifc = 1'b0;
        forever #(period_ns / 2.0) clk_ifc = ~clk_ifc;
    end

endmodule

/* source/router_ingress_top.sv */
// Router ingress stage: per-port packers, FIFOs and counters merged by a round-robin arbiter
// Ports 0 and 1 are the 8-bit ports, ports 2 and 3 the 32-bit ports
`timescale 1ns/1ps

module router_ingress_top (
    input  logic                            clk_ifc,
    input  logic                            rst_n,
    input  ingress_pkg::in8_beat_t          in_8b [ingress_pkg::num_8b_ports],
    input  ingress_pkg::in32_beat_t         in_32b [ingress_pkg::num_32b_ports],
    input  logic [ingress_pkg::num_ports-1:0] port_enable,
    input  logic [ingress_pkg::num_ports-1:0] cnt_clear,
    output ingress_pkg::bus_word_t          out_word,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic [ingress_pkg::cnt_w-1:0]   frame_cnt [ingress_pkg::num_ports],
    output logic [ingress_pkg::cnt_w-1:0]   byte_cnt [ingress_pkg::num_ports],
    output logic [ingress_pkg::num_ports-1:0] buf_overflow
);

    import ingress_pkg::*;

    bus_word_t              packed_word [num_ports];
    logic [num_ports-1:0]   packed_valid;
    logic [num_ports-1:0]   beat_accepted;
    logic [num_ports-1:0]   beat_last;
    bus_word_t              heads [num_ports];
    logic [num_ports-1:0]   not_empty;
    logic [num_ports-1:0]   pop;

    ////////////////////////////////////////
    // Width packers

    for (genvar i = 0; i < num_8b_ports; i++) begin : g_pack_8b
        ingress_width_packer #(
            .in_bytes      ( 1                   )
        ) u_packer (
            .clk_ifc       ( clk_ifc             ),
            .rst_n         ( rst_n               ),
            .beat          ( in_8b[i]            ),
            .enable        ( port_enable[i]      ),
            .port_idx      ( port_idx_w'(i)      ),
            .word          ( packed_word[i]      ),
            .word_valid    ( packed_valid[i]     ),
            .beat_accepted ( beat_accepted[i]    ),
            .beat_last     ( beat_last[i]        )
        );
    end

    for (genvar i = 0; i < num_32b_ports; i++) begin : g_pack_32b
        localparam int p = num_8b_ports + i;
        ingress_width_packer #(
            .in_bytes      ( 4                   )
        ) u_packer (
            .clk_ifc       ( clk_ifc             ),
            .rst_n         ( rst_n               ),
            .beat          ( in_32b[i]           ),
            .enable        ( port_enable[p]      ),
            .port_idx      ( port_idx_w'(p)      ),
            .word          ( packed_word[p]      ),
            .word_valid    ( packed_valid[p]     ),
            .beat_accepted ( beat_accepted[p]    ),
            .beat_last     ( beat_last[p]        )
        );
    end

    ////////////////////////////////////////
    // Per-port buffering and statistics

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        ingress_port_fifo u_fifo (
            .clk_ifc       ( clk_ifc             ),
            .rst_n         ( rst_n               ),
            .wr_word       ( packed_word[p]      ),
            .wr_en         ( packed_valid[p]     ),
            .head          ( heads[p]            ),
            .not_empty     ( not_empty[p]        ),
            .pop           ( pop[p]              ),
            .overflow      ( buf_overflow[p]     )
        );

        ingress_port_counters #(
            .in_bytes      ( (p < num_8b_ports) ? 1 : 4 )
        ) u_counters (
            .clk_ifc       ( clk_ifc             ),
            .rst_n         ( rst_n               ),
            .beat_accepted ( beat_accepted[p]    ),
            .beat_last     ( beat_last[p]        ),
            .clear         ( cnt_clear[p]        ),
            .frame_cnt     ( frame_cnt[p]        ),
            .byte_cnt      ( byte_cnt[p]         )
        );
    end

    ingress_rr_arbiter u_arbiter (
        .clk_ifc   ( clk_ifc   ),
        .rst_n     ( rst_n     ),
        .heads     ( heads     ),
        .not_empty ( not_empty ),
        .pop       ( pop       ),
        .out_word  ( out_word  ),
        .out_valid ( out_valid ),
        .out_ready ( out_ready )
    );

endmodule

/* source/ingress_rr_arbiter.sv */
// Round-robin packet arbiter over the port FIFOs, drives the registered converged bus
// A port keeps the bus until its last word is loaded into the output register
`timescale 1ns/1ps

module ingress_rr_arbiter (
    input  logic                                  clk_ifc,
    input  logic                                  rst_n,
    input  ingress_pkg::bus_word_t                heads [ingress_pkg::num_ports],
    input  logic [ingress_pkg::num_ports-1:0]     not_empty,
    output logic [ingress_pkg::num_ports-1:0]     pop,
    output ingress_pkg::bus_word_t                out_word,
    output logic                                  out_valid,
    input  logic                                  out_ready
);

    import ingress_pkg::*;

    arb_state_e             state;
    logic [port_idx_w-1:0]  cur_port;
    logic [port_idx_w-1:0]  last_port;
    logic [port_idx_w-1:0]  next_port;
    logic [port_idx_w-1:0]  cand;
    logic                   found;
    logic                   load;

    ////////////////////////////////////////
    // Port search starting after the last served port

    always_comb begin
        found     = 1'b0;
        next_port = last_port;
        cand      = last_port;
        for (int i = 1; i <= num_ports; i++) begin
            cand = port_idx_w'((int'(last_port) + i) % num_ports);
            if (!found && not_empty[cand]) begin
                found     = 1'b1;
                next_port = cand;
            end
        end
    end

    // Load when the output register is free or being drained
    assign load = (state == arb_pass) && not_empty[cur_port] && (!out_valid || out_ready);

    always_comb begin
        pop           = '0;
        pop[cur_port] = load;
    end

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            state     <= arb_idle;
            cur_port  <= '0;
            last_port <= port_idx_w'(num_ports - 1);
            out_valid <= 1'b0;
        end else begin
            if (load) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            case (state)
                arb_idle: begin
                    if (found) begin
                        cur_port <= next_port;
                        state    <= arb_pass;
                    end
                end
                arb_pass: begin
                    if (load && heads[cur_port].last) begin
                        last_port <= cur_port;
                        state     <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (load) begin
            out_word <= heads[cur_port];
        end
    end

endmodule

/* source/ingress_port_counters.sv */
// Frame and byte counters for one ingress port, fed by the packer strobes
`timescale 1ns/1ps

module ingress_port_counters #(
    parameter int in_bytes = 1
) (
    input  logic                         clk_ifc,
    input  logic                         rst_n,
    input  logic                         beat_accepted,
    input  logic                         beat_last,
    input  logic                         clear,
    output logic [ingress_pkg::cnt_w-1:0] frame_cnt,
    output logic [ingress_pkg::cnt_w-1:0] byte_cnt
);

    import ingress_pkg::*;

    // Clear wins over a beat in the same cycle
    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            frame_cnt <= '0;
            byte_cnt  <= '0;
        end else if (clear) begin
            frame_cnt <= '0;
            byte_cnt  <= '0;
        end else if (beat_accepted) begin
            byte_cnt <= byte_cnt + cnt_w'(in_bytes);
            if (beat_last) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

endmodule

/* source/ingress_port_fifo.sv */
// Word buffer for one ingress port, drops writes when full and keeps a sticky overflow flag
// Head word is shown directly, pop advances it at the clock edge
`timescale 1ns/1ps

module ingress_port_fifo (
    input  logic                   clk_ifc,
    input  logic                   rst_n,
    input  ingress_pkg::bus_word_t wr_word,
    input  logic                   wr_en,
    output ingress_pkg::bus_word_t head,
    output logic                   not_empty,
    input  logic                   pop,
    output logic                   overflow
);

    import ingress_pkg::*;

    localparam int ptr_w = $clog2(fifo_depth);

    bus_word_t         mem [fifo_depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [ptr_w:0]    count;
    logic              full;
    logic              do_wr;
    logic              do_rd;

    assign full      = (count == (ptr_w+1)'(fifo_depth));
    assign not_empty = (count != '0);
    assign do_wr     = wr_en && !full;
    assign do_rd     = pop && not_empty;
    assign head      = mem[rd_ptr];

    ////////////////////////////////////////
    // Pointers, occupancy and overflow

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Sticky until reset
            if (wr_en && full) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_word;
        end
    end

endmodule

/* source/ingress_width_packer.sv */
// Packs the beats of one physical port into 64-bit bus words with byte keep
// One instance per port, in_bytes set to the port width in bytes (1 or 4)
`timescale 1ns/1ps

module ingress_width_packer #(
    parameter int in_bytes = 1
) (
    input  logic                              clk_ifc,
    input  logic                              rst_n,
    input  logic [in_bytes*8+1:0]             beat,
    input  logic                              enable,
    input  logic [ingress_pkg::port_idx_w-1:0] port_idx,
    output ingress_pkg::bus_word_t            word,
    output logic                              word_valid,
    output logic                              beat_accepted,
    output logic                              beat_last
);

    import ingress_pkg::*;

    localparam int slots  = bus_bytes / in_bytes;
    localparam int slot_w = $clog2(slots);

    logic                    in_valid;
    logic [in_bytes*8-1:0]   in_data;
    logic                    in_last;
    logic                    in_pkt;
    logic                    pkt_en;
    logic                    take;
    logic                    word_done;
    logic [slot_w-1:0]       slot;
    logic [bus_bytes*8-1:0]  acc_data;
    logic [bus_bytes*8-1:0]  next_data;
    logic [bus_bytes-1:0]    next_keep;

    // Beat layout is valid, data, last from MSB down
    assign in_valid = beat[in_bytes*8+1];
    assign in_data  = beat[in_bytes*8:1];
    assign in_last  = beat[0];

    // Enable is sampled on the first beat, later beats follow that decision
    assign take          = in_pkt ? pkt_en : enable;
    assign beat_accepted = in_valid && take;
    assign beat_last     = beat_accepted && in_last;
    assign word_done     = beat_accepted && (in_last || slot == slot_w'(slots - 1));

    always_comb begin
        next_data = acc_data;
        next_data[int'(slot)*in_bytes*8 +: in_bytes*8] = in_data;
        for (int b = 0; b < bus_bytes; b++) begin
            next_keep[b] = (b < (int'(slot) + 1) * in_bytes);
        end
    end

    ////////////////////////////////////////
    // Packet tracking and slot position

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            in_pkt     <= 1'b0;
            pkt_en     <= 1'b0;
            slot       <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= word_done;
            if (in_valid) begin
                if (!in_pkt) begin
                    pkt_en <= enable;
                end
                in_pkt <= !in_last;
            end
            if (beat_accepted) begin
                slot <= word_done ? '0 : slot + 1'b1;
            end
        end
    end

    // Accumulator and output word
    always_ff @(posedge clk_ifc) begin
        if (beat_accepted) begin
            acc_data <= next_data;
        end
        if (word_done) begin
            word.data <= next_data;
            word.keep <= next_keep;
            word.last <= in_last;
            word.port <= port_idx;
        end
    end

endmodule

/* source/ingress_pkg.sv */
// Shared sizes, beat and bus word types and the arbiter state for the router ingress stage
// Imported by every ingress module and by the testbench

package ingress_pkg;

    ////////////////////////////////////////
    // Port counts and sizes

    localparam int num_8b_ports  = 2;
    localparam int num_32b_ports = 2;
    // 8-bit ports take the low indices, 32-bit ports follow
    localparam int num_ports     = num_8b_ports + num_32b_ports;
    localparam int port_idx_w    = 2;
    localparam int bus_bytes     = 8;
    localparam int fifo_depth    = 16;
    localparam int cnt_w         = 32;

    ////////////////////////////////////////
    // Beats and words

    // One beat from an 8-bit physical port
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       last;
    } in8_beat_t;

    // One beat from a 32-bit physical port
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic        last;
    } in32_beat_t;

    // Converged bus word, byte 0 in the low bits of data
    typedef struct packed {
        logic [bus_bytes*8-1:0] data;
        logic [bus_bytes-1:0]   keep;
        logic                   last;
        logic [port_idx_w-1:0]  port;
    } bus_word_t;

    typedef enum logic {
        arb_idle,
        arb_pass
    } arb_state_e;

endpackage
